//--- ahb_slv.f
design/ahb_slv_pkg.sv
design/ahb_req_if.sv
design/ahb_beat_if.sv
design/ahb_addr_gen.sv
design/ahb_burst_check.sv
design/ahb_byte_mem.sv
design/ahb_slv.sv
tests/ahb_slv_asserts.sv
tests/ahb_slv_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the AHB slave testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ahb_slv_tb -f ahb_slv.f -o ahb_slv_sim

./obj_dir/ahb_slv_sim +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
  exit 0
fi
echo "run.sh: simulation did not pass"
exit 1

//--- tests/ahb_slv_tb.sv
`timescale 1ns/1ps

module ahb_slv_tb;
  import ahb_slv_pkg::*;

  localparam int RESET_CYCLES  = 16;
  localparam int RESET_TIMEOUT = 64;

  typedef struct {
    logic   sel;
    logic   write;
    trans_t trans;
    size_t  size;
    burst_t burst;
    haddr_t addr;
    data_t  wdata;
    logic   strobe;
    resp_t  resp;
    data_t  rdata;
  } row_t;

  logic   clk;
  logic   hrst;
  logic   hsel;
  logic   hwrite;
  trans_t htrans;
  size_t  hsize;
  burst_t hburst;
  haddr_t haddr;
  data_t  hwdata;
  logic   hready;
  resp_t  hresp;
  data_t  hrdata;

  row_t   rows[$];
  int     value_errs;
  int     strobe_errs;
  int     assert_errs;
  int     wait_cycles;
  logic   timed_out;

  ahb_slv dut_i (
    .clk    (clk),
    .hrst   (hrst),
    .hsel   (hsel),
    .hwrite (hwrite),
    .htrans (htrans),
    .hsize  (hsize),
    .hburst (hburst),
    .haddr  (haddr),
    .hwdata (hwdata),
    .hready (hready),
    .hresp  (hresp),
    .hrdata (hrdata)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  initial begin
    hrst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    hrst = 1'b1;
  end

  task automatic add_row(input logic sel, input logic write, input trans_t trans,
                         input size_t size, input burst_t burst, input haddr_t addr,
                         input data_t wdata, input logic strobe, input resp_t resp,
                         input data_t rdata);
    row_t r;
    r.sel    = sel;
    r.write  = write;
    r.trans  = trans;
    r.size   = size;
    r.burst  = burst;
    r.addr   = addr;
    r.wdata  = wdata;
    r.strobe = strobe;
    r.resp   = resp;
    r.rdata  = rdata;
    rows.push_back(r);
  endtask

  task automatic drive_idle();
    hsel   = 1'b0;
    hwrite = 1'b0;
    htrans = IDLE;
    hsize  = BYTE;
    hburst = SINGLE;
    haddr  = '0;
    hwdata = '0;
  endtask

  task automatic drive_row(input row_t r);
    hsel   = r.sel;
    hwrite = r.write;
    htrans = r.trans;
    hsize  = r.size;
    hburst = r.burst;
    haddr  = r.addr;
    hwdata = r.wdata;
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp) begin
      value_errs++;
      $display("mismatch at %0t: %s expected %s got %s", $time, name, exp.name(), act.name());
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      value_errs++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_row(input int idx);
    row_t r;
    r = rows[idx];
    if (hready !== r.strobe) begin
      strobe_errs++;
      if (r.strobe) begin
        $display("row %0d: response strobe missing at %0t", idx, $time);
      end else begin
        $display("row %0d: response strobe where none was due at %0t", idx, $time);
      end
    end
    check_resp($sformatf("hresp (row %0d)", idx), r.resp, hresp);
    // Read data or the zero word of a refused beat
    if (r.strobe && (!r.write || r.resp == ERROR)) begin
      check_data($sformatf("hrdata (row %0d)", idx), r.rdata, hrdata);
    end
  endtask

  task automatic build_table();
    // Single byte, halfword and word, then read back
    add_row(1'b1, 1'b1, NONSEQ, BYTE, SINGLE, 32'h00, 32'hDEADBEA5, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, NONSEQ, HALF, SINGLE, 32'h02, 32'hFFFF5A3C, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, NONSEQ, WORD, SINGLE, 32'h04, 32'h11223344, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b0, NONSEQ, BYTE, SINGLE, 32'h00, 32'h0, 1'b1, OKAY, 32'h000000A5);
    add_row(1'b1, 1'b0, NONSEQ, HALF, SINGLE, 32'h02, 32'h0, 1'b1, OKAY, 32'h00005A3C);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'h04, 32'h0, 1'b1, OKAY, 32'h11223344);

    // INCR4 from 0x40 with junk haddr on every SEQ
    add_row(1'b1, 1'b1, NONSEQ, WORD, INCR4, 32'h40, 32'hA0A1A2A3, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, INCR4, 32'h1F3, 32'hB0B1B2B3, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, INCR4, 32'h1F3, 32'hC0C1C2C3, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, INCR4, 32'h1F3, 32'hD0D1D2D3, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b0, IDLE, BYTE, SINGLE, 32'h0, 32'h0, 1'b0, OKAY, 32'h0);
    add_row(1'b1, 1'b1, NONSEQ, BYTE, INCR, 32'h60, 32'h11, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, BYTE, INCR, 32'h0, 32'h12, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, BYTE, INCR, 32'h0, 32'h13, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, BYTE, INCR, 32'h0, 32'h14, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b0, IDLE, BYTE, SINGLE, 32'h0, 32'h0, 1'b0, OKAY, 32'h0);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'h40, 32'h0, 1'b1, OKAY, 32'hA0A1A2A3);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'h44, 32'h0, 1'b1, OKAY, 32'hB0B1B2B3);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'h48, 32'h0, 1'b1, OKAY, 32'hC0C1C2C3);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'h4C, 32'h0, 1'b1, OKAY, 32'hD0D1D2D3);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'h60, 32'h0, 1'b1, OKAY, 32'h14131211);

    // WRAP4 at 0x88 with a BUSY inside lands 88 8C 80 84
    add_row(1'b1, 1'b1, NONSEQ, WORD, WRAP4, 32'h88, 32'h88880001, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, WRAP4, 32'h0, 32'h8C8C0002, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, BUSY, WORD, WRAP4, 32'h0, 32'h0, 1'b0, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, WRAP4, 32'h0, 32'h80800003, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, WRAP4, 32'h0, 32'h84840004, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b0, IDLE, BYTE, SINGLE, 32'h0, 32'h0, 1'b0, OKAY, 32'h0);
    // WRAP8 halfwords from 0x8C stay in 0x80..0x8F
    add_row(1'b1, 1'b0, NONSEQ, HALF, WRAP8, 32'h8C, 32'h0, 1'b1, OKAY, 32'h00000002);
    add_row(1'b1, 1'b0, SEQ, HALF, WRAP8, 32'h0, 32'h0, 1'b1, OKAY, 32'h00008C8C);
    add_row(1'b1, 1'b0, SEQ, HALF, WRAP8, 32'h0, 32'h0, 1'b1, OKAY, 32'h00000003);
    add_row(1'b1, 1'b0, SEQ, HALF, WRAP8, 32'h0, 32'h0, 1'b1, OKAY, 32'h00008080);
    add_row(1'b1, 1'b0, SEQ, HALF, WRAP8, 32'h0, 32'h0, 1'b1, OKAY, 32'h00000004);
    add_row(1'b1, 1'b0, SEQ, HALF, WRAP8, 32'h0, 32'h0, 1'b1, OKAY, 32'h00008484);
    add_row(1'b1, 1'b0, SEQ, HALF, WRAP8, 32'h0, 32'h0, 1'b1, OKAY, 32'h00000001);
    add_row(1'b1, 1'b0, SEQ, HALF, WRAP8, 32'h0, 32'h0, 1'b1, OKAY, 32'h00008888);
    add_row(1'b1, 1'b0, IDLE, BYTE, SINGLE, 32'h0, 32'h0, 1'b0, OKAY, 32'h0);

    // Refused beats around 0x20 and an unselected write
    add_row(1'b1, 1'b1, NONSEQ, WORD, SINGLE, 32'h20, 32'hCAFEF00D, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, NONSEQ, WORD, SINGLE, 32'h120, 32'hBAD00001, 1'b1, ERROR, 32'h0);
    add_row(1'b1, 1'b1, NONSEQ, HALF, SINGLE, 32'h21, 32'hBAD00002, 1'b1, ERROR, 32'h0);
    add_row(1'b1, 1'b1, NONSEQ, size_t'(3'd3), SINGLE, 32'h20, 32'hBAD00003, 1'b1, ERROR,
            32'h0);
    // Refused read returns zero, not the word at offset 0x20
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'h120, 32'h0, 1'b1, ERROR, 32'h0);
    add_row(1'b0, 1'b1, NONSEQ, WORD, SINGLE, 32'h20, 32'hBAD00006, 1'b0, OKAY, 32'h0);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'h20, 32'h0, 1'b1, OKAY, 32'hCAFEF00D);

    // Fifth beat of an INCR4 would hit 0xB0
    add_row(1'b1, 1'b1, NONSEQ, WORD, SINGLE, 32'hB0, 32'h0B0B0B0B, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, NONSEQ, WORD, INCR4, 32'hA0, 32'hA0A0A0A0, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, INCR4, 32'h0, 32'hA4A4A4A4, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, INCR4, 32'h0, 32'hA8A8A8A8, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, INCR4, 32'h0, 32'hACACACAC, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, INCR4, 32'h0, 32'hBAD00004, 1'b1, ERROR, 32'h0);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'hAC, 32'h0, 1'b1, OKAY, 32'hACACACAC);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'hB0, 32'h0, 1'b1, OKAY, 32'h0B0B0B0B);

    // SEQ after a SINGLE would hit 0xC4
    add_row(1'b1, 1'b1, NONSEQ, WORD, SINGLE, 32'hC4, 32'h4C4C4C4C, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, NONSEQ, WORD, SINGLE, 32'hC0, 32'h0C0C0C0C, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b1, SEQ, WORD, SINGLE, 32'hC4, 32'hBAD00005, 1'b1, ERROR, 32'h0);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'hC4, 32'h0, 1'b1, OKAY, 32'h4C4C4C4C);

    // Back-to-back write then read
    add_row(1'b1, 1'b1, NONSEQ, WORD, SINGLE, 32'h30, 32'h13579BDF, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b0, NONSEQ, WORD, SINGLE, 32'h30, 32'h0, 1'b1, OKAY, 32'h13579BDF);
    add_row(1'b1, 1'b1, NONSEQ, BYTE, SINGLE, 32'h31, 32'h00000066, 1'b1, OKAY, 32'h0);
    add_row(1'b1, 1'b0, NONSEQ, HALF, SINGLE, 32'h30, 32'h0, 1'b1, OKAY, 32'h000066DF);
  endtask

  // One row per cycle with the previous row checked first
  task automatic apply_table();
    for (int i = 0; i <= rows.size(); i++) begin
      @(posedge clk);
      #1;
      if (i > 0) begin
        check_row(i - 1);
      end
      if (i < rows.size()) begin
        drive_row(rows[i]);
      end else begin
        drive_idle();
      end
    end
  endtask

  initial begin
    value_errs  = 0;
    strobe_errs = 0;
    assert_errs = 0;
    wait_cycles = 0;
    timed_out   = 1'b0;
    drive_idle();
    build_table();
    while (hrst !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (hrst !== 1'b1) begin
      timed_out = 1'b1;
      $display("timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
    end else begin
      #1;
      if (hready !== 1'b0) begin
        strobe_errs++;
        $display("hready is not low right after reset at %0t", $time);
      end
      check_resp("hresp", OKAY, hresp);
      check_data("hrdata", 32'h0, hrdata);
      apply_table();
    end
    assert_errs = dut_i.asserts_i.fail_count;
    $display("check summary: %0d value mismatches, %0d strobe errors, %0d assertion failures",
             value_errs, strobe_errs, assert_errs);
    if (timed_out || (value_errs + strobe_errs + assert_errs) != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

//--- tests/ahb_slv_asserts.sv
`timescale 1ns/1ps

module ahb_slv_asserts (
  input logic                clk,
  input logic                hrst,
  input logic                hsel,
  input ahb_slv_pkg::trans_t htrans,
  input logic                hready,
  input ahb_slv_pkg::resp_t  hresp
);
  import ahb_slv_pkg::*;

  int   fail_count = 0;
  logic req_valid;

  assign req_valid = hsel && (htrans == NONSEQ || htrans == SEQ);

  // No request, no strobe in the next cycle
  strobe_needs_req: assert property (@(posedge clk) disable iff (!hrst)
      !req_valid |=> !hready)
    else begin
      fail_count++;
      $error("hready high without a request in the cycle before");
    end

  req_gets_strobe: assert property (@(posedge clk) disable iff (!hrst)
      req_valid |=> hready)
    else begin
      fail_count++;
      $error("request not followed by hready");
    end

  error_with_strobe: assert property (@(posedge clk) disable iff (!hrst)
      hresp == ERROR |-> hready)
    else begin
      fail_count++;
      $error("hresp ERROR without hready");
    end

  // First cycle out of reset
  quiet_after_reset: assert property (@(posedge clk) $rose(hrst) |-> !hready)
    else begin
      fail_count++;
      $error("hready high in the first cycle after reset");
    end

endmodule

bind ahb_slv ahb_slv_asserts asserts_i (
  .clk    (clk),
  .hrst   (hrst),
  .hsel   (hsel),
  .htrans (htrans),
  .hready (hready),
  .hresp  (hresp)
);

//--- design/ahb_slv.sv
`timescale 1ns/1ps

module ahb_slv (
  input  logic                 clk,
  input  logic                 hrst,
  input  logic                 hsel,
  input  logic                 hwrite,
  input  ahb_slv_pkg::trans_t  htrans,
  input  ahb_slv_pkg::size_t   hsize,
  input  ahb_slv_pkg::burst_t  hburst,
  input  ahb_slv_pkg::haddr_t  haddr,
  input  ahb_slv_pkg::data_t   hwdata,
  output logic                 hready,
  output ahb_slv_pkg::resp_t   hresp,
  output ahb_slv_pkg::data_t   hrdata
);

  ahb_req_if  req_if ();
  ahb_beat_if beat_if ();

  logic beat_err;

  // Request beat straight from the bus pins
  assign req_if.sel   = hsel;
  assign req_if.write = hwrite;
  assign req_if.trans = htrans;
  assign req_if.size  = hsize;
  assign req_if.burst = hburst;
  assign req_if.addr  = haddr;
  assign req_if.wdata = hwdata;

  ahb_addr_gen addr_gen_i (
    .clk  (clk),
    .hrst (hrst),
    .req  (req_if.gen),
    .beat (beat_if.gen)
  );

  ahb_burst_check burst_check_i (
    .clk      (clk),
    .hrst     (hrst),
    .req      (req_if.chk),
    .beat_err (beat_err)
  );

  // Verdict and beat meet here and become the response
  ahb_byte_mem byte_mem_i (
    .clk      (clk),
    .hrst     (hrst),
    .beat     (beat_if.mem),
    .beat_err (beat_err),
    .hready   (hready),
    .hresp    (hresp),
    .hrdata   (hrdata)
  );

endmodule

//--- design/ahb_byte_mem.sv
`timescale 1ns/1ps

module ahb_byte_mem (
  input  logic                clk,
  input  logic                hrst,
  ahb_beat_if.mem             beat,
  input  logic                beat_err,
  output logic                hready,
  output ahb_slv_pkg::resp_t  hresp,
  output ahb_slv_pkg::data_t  hrdata
);
  import ahb_slv_pkg::*;

  logic [7:0] mem [MEM_BYTES];

  logic [3:0] lane_en;
  data_t      rd_word;
  logic       do_access;

  assign do_access = beat.valid && !beat_err;

  always_comb begin
    case (beat.nbytes)
      BYTE:    lane_en = 4'b0001;
      HALF:    lane_en = 4'b0011;
      WORD:    lane_en = 4'b1111;
      default: lane_en = 4'b0000;
    endcase
  end

  // Little endian, lane i sits at offset + i
  always_comb begin
    rd_word = '0;
    for (int i = 0; i < 4; i++) begin
      if (lane_en[i]) begin
        rd_word[8*i +: 8] = mem[beat.offset + mem_addr_t'(i)];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_access && beat.write) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_en[i]) begin
          mem[beat.offset + mem_addr_t'(i)] <= beat.wdata[8*i +: 8];
        end
      end
    end
  end

  // One-cycle response strobe per beat
  always_ff @(posedge clk) begin
    if (!hrst) begin
      hready <= 1'b0;
      hresp  <= OKAY;
      hrdata <= '0;
    end else begin
      hready <= beat.valid;
      hresp  <= (beat.valid && beat_err) ? ERROR : OKAY;
      if (beat.valid) begin
        hrdata <= (do_access && !beat.write) ? rd_word : '0;
      end
    end
  end

endmodule

//--- design/ahb_burst_check.sv
`timescale 1ns/1ps

module ahb_burst_check (
  input  logic   clk,
  input  logic   hrst,
  ahb_req_if.chk req,
  output logic   beat_err
);
  import ahb_slv_pkg::*;

  logic      open;
  logic      unbounded;
  beat_cnt_t remaining;

  logic      valid;
  logic      is_nonseq;
  logic      is_seq;
  logic      range_bad;
  logic      size_bad;
  logic      misaligned;
  logic      seq_bad;

  assign is_nonseq = req.trans == NONSEQ;
  assign is_seq    = req.trans == SEQ;
  assign valid     = req.sel && (is_nonseq || is_seq);

  // Address checks apply to NONSEQ only
  assign range_bad = is_nonseq && (req.addr >= haddr_t'(MEM_BYTES));
  assign size_bad  = req.size > WORD;

  always_comb begin
    misaligned = 1'b0;
    if (is_nonseq) begin
      case (req.size)
        HALF:    misaligned = req.addr[0];
        WORD:    misaligned = req.addr[1:0] != 2'b00;
        default: misaligned = 1'b0;
      endcase
    end
  end

  // No open burst, or a fixed burst already used up
  assign seq_bad = is_seq && (!open || (!unbounded && remaining == '0));

  assign beat_err = valid && (range_bad || size_bad || misaligned || seq_bad);

  always_ff @(posedge clk) begin
    if (!hrst) begin
      open      <= 1'b0;
      unbounded <= 1'b0;
      remaining <= '0;
    end else if (valid) begin
      if (beat_err) begin
        open <= 1'b0;
      end else if (is_nonseq) begin
        open      <= req.burst != SINGLE;
        unbounded <= req.burst == INCR;
        // Counts the SEQ beats still allowed
        remaining <= beats_of(req.burst) - beat_cnt_t'(1);
      end else if (!unbounded) begin
        remaining <= remaining - beat_cnt_t'(1);
      end
    end else if (req.sel && req.trans == IDLE) begin
      open <= 1'b0;
    end
    // BUSY falls through and keeps the burst as it is
  end

endmodule

//--- design/ahb_addr_gen.sv
`timescale 1ns/1ps

module ahb_addr_gen (
  input  logic       clk,
  input  logic       hrst,
  ahb_req_if.gen     req,
  ahb_beat_if.gen    beat
);
  import ahb_slv_pkg::*;

  mem_addr_t next_off;
  mem_addr_t cur_off;
  mem_addr_t incr_off;
  mem_addr_t step;
  mem_addr_t wrap_mask;
  mem_addr_t step_off;
  logic      is_wrap;
  logic      beat_valid;

  assign beat_valid = req.sel && (req.trans == NONSEQ || req.trans == SEQ);

  always_comb begin
    case (req.size)
      BYTE:    step = mem_addr_t'(1);
      HALF:    step = mem_addr_t'(2);
      default: step = mem_addr_t'(4);
    endcase
  end

  assign is_wrap = (req.burst == WRAP4) || (req.burst == WRAP8) ||
                   (req.burst == WRAP16);

  // Wrap block is beats x bytes, aligned to its own size
  assign wrap_mask = mem_addr_t'(mem_addr_t'(beats_of(req.burst)) * step - 8'd1);

  // SEQ beats ignore haddr and follow the stored offset
  assign cur_off  = (req.trans == NONSEQ) ? req.addr[MEM_AW-1:0] : next_off;
  assign incr_off = cur_off + step;

  always_comb begin
    if (is_wrap) begin
      step_off = (cur_off & ~wrap_mask) | (incr_off & wrap_mask);
    end else begin
      // Runs past the top wrap to offset 0
      step_off = incr_off;
    end
  end

  always_ff @(posedge clk) begin
    if (!hrst) begin
      next_off <= '0;
    end else if (beat_valid) begin
      next_off <= step_off;
    end
  end

  assign beat.valid  = beat_valid;
  assign beat.offset = cur_off;
  assign beat.nbytes = req.size;
  assign beat.write  = req.write;
  assign beat.wdata  = req.wdata;

endmodule

//--- design/ahb_beat_if.sv
`timescale 1ns/1ps

interface ahb_beat_if;
  import ahb_slv_pkg::*;

  // One-cycle strobe per accepted beat
  logic      valid;
  mem_addr_t offset;
  size_t     nbytes;
  logic      write;
  data_t     wdata;

  modport gen (
    output valid, offset, nbytes, write, wdata
  );

  modport mem (
    input valid, offset, nbytes, write, wdata
  );

endinterface

//--- design/ahb_req_if.sv
`timescale 1ns/1ps

interface ahb_req_if;
  import ahb_slv_pkg::*;

  logic   sel;
  logic   write;
  trans_t trans;
  size_t  size;
  burst_t burst;
  haddr_t addr;
  data_t  wdata;

  modport src (
    output sel, write, trans, size, burst, addr, wdata
  );

  modport gen (
    input sel, write, trans, size, burst, addr, wdata
  );

  // Burst checker never looks at the data path
  modport chk (
    input sel, trans, size, burst, addr
  );

  modport mem (
    input write, wdata
  );

endinterface

//--- design/ahb_slv_pkg.sv
package ahb_slv_pkg;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int MEM_BYTES = 256;
  localparam int MEM_AW    = 8;
  localparam int MAX_BEATS = 16;

  // Transfer type encodings
  typedef enum logic [1:0] {
    NONSEQ = 2'd0,
    SEQ    = 2'd1,
    BUSY   = 2'd2,
    IDLE   = 2'd3
  } trans_t;

  // Slave response, RETRY and SPLIT not supported
  typedef enum logic [1:0] {
    OKAY  = 2'd0,
    ERROR = 2'd1
  } resp_t;

  typedef enum logic [2:0] {
    SINGLE = 3'd0,
    INCR   = 3'd1,
    WRAP4  = 3'd2,
    INCR4  = 3'd3,
    WRAP8  = 3'd4,
    INCR8  = 3'd5,
    WRAP16 = 3'd6,
    INCR16 = 3'd7
  } burst_t;

  // Values 3 to 7 are illegal
  typedef enum logic [2:0] {
    BYTE = 3'd0,
    HALF = 3'd1,
    WORD = 3'd2
  } size_t;

  typedef logic [ADDR_W-1:0]               haddr_t;
  typedef logic [DATA_W-1:0]               data_t;
  typedef logic [MEM_AW-1:0]               mem_addr_t;
  typedef logic [$clog2(MAX_BEATS+1)-1:0]  beat_cnt_t;

  // Beats in a fixed-length burst, 0 for undefined INCR
  function automatic beat_cnt_t beats_of(input burst_t kind);
    case (kind)
      SINGLE:        beats_of = beat_cnt_t'(1);
      WRAP4, INCR4:  beats_of = beat_cnt_t'(4);
      WRAP8, INCR8:  beats_of = beat_cnt_t'(8);
      WRAP16, INCR16: beats_of = beat_cnt_t'(MAX_BEATS);
      default:       beats_of = '0;
    endcase
  endfunction

endpackage
